/* compile.f */
+incdir+tests
rtl/uart_pkg.sv
rtl/uart_baud_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_line_status.sv
rtl/uart_top.sv
tests/uart_tb.sv

/* tests/uart_tb_tasks.svh */
// ----------------------------------------------------------------------
// random numbers, reporting, small helpers
// ----------------------------------------------------------------------
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] rand_next();
  rng_state = xorshift32(rng_state);  // advances the shared stream
  return rng_state;
endfunction

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
  mismatches++;
  $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
endtask

task automatic report_failure(input string what);
  failures++;
  $display("Error at %0t ns: %s", $time, what);
endtask

task automatic wait_cycles(input int n);
  repeat (n) @(negedge clk);
endtask

task automatic pulse_status_read();
  status_read_i = 1'b1;
  @(negedge clk);
  status_read_i = 1'b0;
endtask

task automatic pulse_rx_read();
  rx_read_i = 1'b1;
  @(negedge clk);
  rx_read_i = 1'b0;
endtask

task automatic wait_tx_done();
  while (!lsr_o[uart_pkg::LSR_TEMT])
    @(negedge clk);
endtask

// priority order is line status, then data at trigger, then tx empty
function automatic logic [uart_pkg::IIR_W-1:0] expected_iir(
  input logic [uart_pkg::LSR_W-1:0] lsr,
  input logic [CNT_W-1:0]           cnt,
  input logic [2:0]                 ier,
  input logic [CNT_W-1:0]           trig
);
  if (ier[uart_pkg::IER_RLS] && ((lsr & ERR_MASK) != '0))
    return uart_pkg::IIR_RLS;
  if (ier[uart_pkg::IER_RDA] && trig != '0 && cnt >= trig)
    return uart_pkg::IIR_RDA;
  if (ier[uart_pkg::IER_THRE] && lsr[uart_pkg::LSR_TFE])
    return uart_pkg::IIR_THRE;
  return uart_pkg::IIR_NONE;
endfunction

// one frame on the bit-bang line followed by two idle bits
task automatic send_serial(input logic [7:0] data, input logic par_en,
                           input logic par_flip, input logic stop);
  int i;
  bb_line = 1'b0;  // start
  wait_cycles(BIT_CYC);
  for (i = 0; i < 8; i++)
  begin
    bb_line = data[i];  // lsb first
    wait_cycles(BIT_CYC);
  end
  if (par_en)
  begin
    bb_line = (^data) ^ par_flip;  // even parity unless flipped
    wait_cycles(BIT_CYC);
  end
  bb_line = stop;
  wait_cycles(BIT_CYC);
  bb_line = 1'b1;
  wait_cycles(2 * BIT_CYC);
endtask

// ----------------------------------------------------------------------
// test bodies
// ----------------------------------------------------------------------
task automatic check_reset_values();
  if (txd_o !== 1'b1)
    report_mismatch("txd_o", txd_o, 1);
  if (tx_credit_o !== CNT_W'(FIFO_DEPTH))
    report_mismatch("tx_credit_o", tx_credit_o, FIFO_DEPTH);
  if (rx_count_o !== '0)
    report_mismatch("rx_count_o", rx_count_o, 0);
  if (irq_o !== 1'b0)
    report_mismatch("irq_o", irq_o, 0);
  if (lsr_o !== LSR_RST)
    report_mismatch("lsr_o", lsr_o, LSR_RST);
  if (iir_o !== uart_pkg::IIR_NONE)
    report_mismatch("iir_o", iir_o, uart_pkg::IIR_NONE);
endtask

task automatic stream_loopback(input int n);
  int          sent;
  int          got;
  logic [31:0] r;
  logic [7:0]  b;
  sent     = 0;
  got      = 0;
  loopback = 1'b1;
  exp_q.delete();
  while (got < n)
  begin
    @(negedge clk);
    tx_write_i = 1'b0;
    rx_read_i  = 1'b0;
    if (rx_count_o != '0)
    begin
      if (exp_q.size() == 0)
        report_failure("byte received with none outstanding");
      else
      begin
        b = exp_q.pop_front();
        if (rx_data_o !== b)
          report_mismatch("rx_data_o", rx_data_o, b);
      end
      rx_read_i = 1'b1;
      got++;
    end
    r = rand_next();
    if (sent < n && tx_credit_o != '0 && r[1:0] != 2'b00)  // random gaps
    begin
      tx_data_i  = r[15:8];
      tx_write_i = 1'b1;
      exp_q.push_back(r[15:8]);
      sent++;
    end
  end
  @(negedge clk);
  tx_write_i = 1'b0;
  rx_read_i  = 1'b0;
  wait_tx_done();
  wait_cycles(1);
  if (tx_credit_o !== CNT_W'(FIFO_DEPTH))
    report_mismatch("tx_credit_o", tx_credit_o, FIFO_DEPTH);
  if (!lsr_o[uart_pkg::LSR_TFE])
    report_mismatch("lsr_o[TFE]", lsr_o[uart_pkg::LSR_TFE], 1);
  if ((lsr_o & ERR_MASK) !== '0)
    report_mismatch("lsr_o error bits", lsr_o & ERR_MASK, 0);
endtask

task automatic overflow_rx_fifo();
  int          sent;
  int          i;
  logic [31:0] r;
  sent     = 0;
  loopback = 1'b1;
  exp_q.delete();
  while (sent < FIFO_DEPTH + 3)  // no reads so the last three frames are dropped
  begin
    @(negedge clk);
    tx_write_i = 1'b0;
    if (tx_credit_o != '0)
    begin
      r          = rand_next();
      tx_data_i  = r[7:0];
      tx_write_i = 1'b1;
      exp_q.push_back(r[7:0]);
      sent++;
    end
  end
  @(negedge clk);
  tx_write_i = 1'b0;
  wait_tx_done();
  wait_cycles(4);
  if (rx_count_o !== CNT_W'(FIFO_DEPTH))
    report_mismatch("rx_count_o", rx_count_o, FIFO_DEPTH);
  if (lsr_o[uart_pkg::LSR_OE] !== 1'b1)
    report_mismatch("lsr_o[OE]", lsr_o[uart_pkg::LSR_OE], 1);
  if (lsr_o[uart_pkg::LSR_DR] !== 1'b1)
    report_mismatch("lsr_o[DR]", lsr_o[uart_pkg::LSR_DR], 1);
  for (i = 0; i < FIFO_DEPTH; i++)
  begin
    if (rx_data_o !== exp_q[i])
      report_mismatch("rx_data_o", rx_data_o, exp_q[i]);
    pulse_rx_read();
  end
  pulse_status_read();
  if (lsr_o[uart_pkg::LSR_OE] !== 1'b0)
    report_mismatch("lsr_o[OE]", lsr_o[uart_pkg::LSR_OE], 0);
  pulse_rx_read();  // fifo empty now
  wait_cycles(2);
  if (lsr_o[uart_pkg::LSR_UE] !== 1'b1)
    report_mismatch("lsr_o[UE]", lsr_o[uart_pkg::LSR_UE], 1);
  pulse_status_read();
  wait_cycles(1);
  if ((lsr_o & ERR_MASK) !== '0)
    report_mismatch("lsr_o error bits", lsr_o & ERR_MASK, 0);
endtask

// frame with one error bit is checked then cleared
task automatic check_error_frame(input logic [7:0] data, input int bit_idx);
  if (rx_count_o !== CNT_W'(1))
    report_mismatch("rx_count_o", rx_count_o, 1);
  if (rx_data_o !== data)
    report_mismatch("rx_data_o", rx_data_o, data);  // kept despite the error
  if ((lsr_o & ERR_MASK) !== uart_pkg::LSR_W'(1 << bit_idx))
    report_mismatch("lsr_o error bits", lsr_o & ERR_MASK, 1 << bit_idx);
  if (irq_o !== 1'b1)
    report_mismatch("irq_o", irq_o, 1);
  if (iir_o !== uart_pkg::IIR_RLS)
    report_mismatch("iir_o", iir_o, uart_pkg::IIR_RLS);
  pulse_rx_read();
  pulse_status_read();
  wait_cycles(1);
  if ((lsr_o & ERR_MASK) !== '0)
    report_mismatch("lsr_o error bits", lsr_o & ERR_MASK, 0);
  if (irq_o !== 1'b0)
    report_mismatch("irq_o", irq_o, 0);
endtask

task automatic inject_error_frames();
  logic [31:0] r;
  r        = rand_next();
  ier_i    = 3'b001;  // line status only
  loopback = 1'b0;
  parity_en_i = 1'b0;
  send_serial(r[7:0], 1'b0, 1'b0, 1'b0);   // stop bit low
  check_error_frame(r[7:0], uart_pkg::LSR_FE);
  parity_en_i = 1'b1;
  send_serial(r[15:8], 1'b1, 1'b1, 1'b1);  // wrong parity
  check_error_frame(r[15:8], uart_pkg::LSR_PE);
  parity_en_i = 1'b0;
  ier_i       = 3'b000;
  loopback    = 1'b1;
endtask

task automatic step_interrupt_priority();
  int          i;
  logic [31:0] r;
  ier_i     = 3'b111;
  trigger_i = CNT_W'(2);
  loopback  = 1'b1;
  exp_q.delete();
  wait_cycles(3);
  if (iir_o !== uart_pkg::IIR_THRE)  // only the tx side is pending
    report_mismatch("iir_o", iir_o, uart_pkg::IIR_THRE);
  pulse_rx_read();  // underrun raises line status
  wait_cycles(3);
  if (iir_o !== uart_pkg::IIR_RLS)
    report_mismatch("iir_o", iir_o, uart_pkg::IIR_RLS);
  for (i = 0; i < 2; i++)
  begin
    r          = rand_next();
    tx_data_i  = r[7:0];
    tx_write_i = 1'b1;
    exp_q.push_back(r[7:0]);
    @(negedge clk);
  end
  tx_write_i = 1'b0;
  while (rx_count_o != CNT_W'(2))
    @(negedge clk);
  wait_cycles(2);
  if (iir_o !== uart_pkg::IIR_RLS)  // rls still above rda
    report_mismatch("iir_o", iir_o, uart_pkg::IIR_RLS);
  pulse_status_read();
  wait_cycles(1);
  if (iir_o !== uart_pkg::IIR_RDA)
    report_mismatch("iir_o", iir_o, uart_pkg::IIR_RDA);
  for (i = 0; i < 2; i++)
  begin
    if (rx_data_o !== exp_q[i])
      report_mismatch("rx_data_o", rx_data_o, exp_q[i]);
    pulse_rx_read();
  end
  wait_cycles(2);
  if (iir_o !== uart_pkg::IIR_THRE)
    report_mismatch("iir_o", iir_o, uart_pkg::IIR_THRE);
  ier_i = 3'b000;  // everything masked
  wait_cycles(2);
  for (i = 0; i < 8; i++)
  begin
    if (irq_o !== 1'b0)
      report_mismatch("irq_o", irq_o, 0);
    if (iir_o !== uart_pkg::IIR_NONE)
      report_mismatch("iir_o", iir_o, uart_pkg::IIR_NONE);
    @(negedge clk);
  end
  trigger_i = '0;
endtask

/* tests/uart_tb.sv */
`timescale 1ns/10ps

module uart_tb;

  localparam int FIFO_DEPTH   = 8;
  localparam int DIV_W        = 12;
  localparam int CNT_W        = $clog2(FIFO_DEPTH + 1);
  localparam int DIVISOR      = 2;
  localparam int BIT_CYC      = uart_pkg::OVERSAMPLE * DIVISOR;  // clocks per bit
  localparam int N_LOOP       = 24;                              // frames per loopback pass
  // two loopback passes, overrun burst, two bit-banged frames, two priority frames
  localparam int TOTAL_FRAMES = 2 * N_LOOP + FIFO_DEPTH + 3 + 2 + 2;
  localparam longint LIMIT_NS = longint'(TOTAL_FRAMES) * 11 * BIT_CYC * 20 + 200_000;

  localparam logic [uart_pkg::LSR_W-1:0] ERR_MASK =
    uart_pkg::LSR_W'((1 << uart_pkg::LSR_OE) | (1 << uart_pkg::LSR_PE)
                     | (1 << uart_pkg::LSR_FE) | (1 << uart_pkg::LSR_UE));
  localparam logic [uart_pkg::LSR_W-1:0] LSR_RST =
    uart_pkg::LSR_W'((1 << uart_pkg::LSR_TFE) | (1 << uart_pkg::LSR_TEMT));

  logic                        clk;
  logic                        rst_i;
  logic [DIV_W-1:0]            divisor_i;
  logic                        parity_en_i;
  logic [2:0]                  ier_i;
  logic [CNT_W-1:0]            trigger_i;
  logic [uart_pkg::DATA_W-1:0] tx_data_i;
  logic                        tx_write_i;
  logic [CNT_W-1:0]            tx_credit_o;
  logic [uart_pkg::DATA_W-1:0] rx_data_o;
  logic                        rx_read_i;
  logic [CNT_W-1:0]            rx_count_o;
  logic                        status_read_i;
  logic [uart_pkg::LSR_W-1:0]  lsr_o;
  logic [uart_pkg::IIR_W-1:0]  iir_o;
  logic                        irq_o;
  logic                        rxd;
  logic                        txd_o;
  logic                        loopback;   // rxd from txd_o or the bit-bang line
  logic                        bb_line;

  // model state
  logic [uart_pkg::DATA_W-1:0] exp_q [$];  // bytes still to arrive
  logic [31:0]                 rng_state = 32'hfdbc07f8;
  int                          mismatches = 0;
  int                          failures   = 0;
  int                          credit_model;
  int                          tx_frame_left;  // cycles until the shifter can start again
  logic                        txd_prev;
  logic [uart_pkg::LSR_W-1:0]  prev_lsr;
  logic [CNT_W-1:0]            prev_cnt;
  logic [uart_pkg::IIR_W-1:0]  exp_iir;
  // inputs as seen by the dut at the last rising edge
  logic                        rst_q = 1'b1;
  logic                        wr_q  = 1'b0;
  logic [2:0]                  ier_q = 3'b000;
  logic [CNT_W-1:0]            trig_q = '0;

  `include "uart_tb_tasks.svh"

  assign rxd = loopback ? txd_o : bb_line;

  uart_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .DIV_W      (DIV_W)
  ) uart_top_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .divisor_i     (divisor_i),
    .parity_en_i   (parity_en_i),
    .ier_i         (ier_i),
    .trigger_i     (trigger_i),
    .tx_data_i     (tx_data_i),
    .tx_write_i    (tx_write_i),
    .tx_credit_o   (tx_credit_o),
    .rx_data_o     (rx_data_o),
    .rx_read_i     (rx_read_i),
    .rx_count_o    (rx_count_o),
    .status_read_i (status_read_i),
    .lsr_o         (lsr_o),
    .iir_o         (iir_o),
    .irq_o         (irq_o),
    .rxd_i         (rxd),
    .txd_o         (txd_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 50 MHz
  end

  // ----------------------------------------------------------------------
  // credit and interrupt monitors run every cycle
  // ----------------------------------------------------------------------
  always @(posedge clk)
  begin
    rst_q  <= rst_i;
    wr_q   <= tx_write_i;
    ier_q  <= ier_i;
    trig_q <= trigger_i;
  end

  always @(negedge clk)
  begin
    if (rst_q)
    begin
      credit_model  = FIFO_DEPTH;
      tx_frame_left = 0;
    end
    else
    begin
      if (wr_q)
        credit_model = credit_model - 1;
      if (tx_frame_left > 0)
        tx_frame_left = tx_frame_left - 1;  // falls inside a frame are data bits
      else if (txd_prev && !txd_o)
      begin
        credit_model  = credit_model + 1;  // start bit means the shifter took one
        tx_frame_left = (parity_en_i ? 11 : 10) * BIT_CYC;
      end
      if (tx_credit_o !== CNT_W'(credit_model))
        report_mismatch("tx_credit_o", tx_credit_o, credit_model);
      if (tx_credit_o > CNT_W'(FIFO_DEPTH))
        report_failure("tx credit above the fifo depth");
      // iir follows status and count one cycle late
      exp_iir = expected_iir(prev_lsr, prev_cnt, ier_q, trig_q);
      if (iir_o !== exp_iir)
        report_mismatch("iir_o", iir_o, exp_iir);
      if (irq_o !== (exp_iir != uart_pkg::IIR_NONE))
        report_mismatch("irq_o", irq_o, exp_iir != uart_pkg::IIR_NONE);
    end
    txd_prev = txd_o;
    prev_lsr = lsr_o;
    prev_cnt = rx_count_o;
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    rst_i         = 1'b1;
    divisor_i     = DIV_W'(DIVISOR);
    parity_en_i   = 1'b0;
    ier_i         = 3'b000;
    trigger_i     = '0;
    tx_data_i     = '0;
    tx_write_i    = 1'b0;
    rx_read_i     = 1'b0;
    status_read_i = 1'b0;
    loopback      = 1'b1;
    bb_line       = 1'b1;  // idle line
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    @(negedge clk);
    check_reset_values();

    parity_en_i = 1'b0;
    stream_loopback(N_LOOP);
    parity_en_i = 1'b1;
    stream_loopback(N_LOOP);
    parity_en_i = 1'b0;
    overflow_rx_fifo();
    inject_error_frames();
    step_interrupt_priority();

    wait_cycles(4);
    $display("mismatches: %0d  other errors: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // watchdog sized from the frame count
  initial
  begin
    #(LIMIT_NS);
    report_failure("watchdog expired before the tests finished");
    $display("mismatches: %0d  other errors: %0d", mismatches, failures);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* rtl/uart_top.sv */
`timescale 1ns/10ps

module uart_top #(
  parameter int FIFO_DEPTH = 8,
  parameter int DIV_W      = 12,
  parameter int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic [DIV_W-1:0]            divisor_i,
  input  logic                        parity_en_i,
  input  logic [2:0]                  ier_i,
  input  logic [CNT_W-1:0]            trigger_i,
  // transmit, credit flow control
  input  logic [uart_pkg::DATA_W-1:0] tx_data_i,
  input  logic                        tx_write_i,
  output logic [CNT_W-1:0]            tx_credit_o,
  // receive
  output logic [uart_pkg::DATA_W-1:0] rx_data_o,
  input  logic                        rx_read_i,
  output logic [CNT_W-1:0]            rx_count_o,
  // status and interrupt
  input  logic                        status_read_i,
  output logic [uart_pkg::LSR_W-1:0]  lsr_o,
  output logic [uart_pkg::IIR_W-1:0]  iir_o,
  output logic                        irq_o,
  // serial pins
  input  logic                        rxd_i,
  output logic                        txd_o
);

  logic tick;        // 16x bit rate
  logic tx_empty;
  logic tx_idle;
  logic frame_done;  // rx events
  logic parity_err;
  logic frame_err;
  logic overrun;
  logic underrun;

  uart_baud_gen #(
    .DIV_W (DIV_W)
  ) baud_gen_i (
    .clk       (clk),
    .rst_i     (rst_i),
    .divisor_i (divisor_i),
    .tick_o    (tick)
  );

  uart_tx #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CNT_W      (CNT_W)
  ) tx_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .tick_i      (tick),
    .parity_en_i (parity_en_i),
    .tx_data_i   (tx_data_i),
    .tx_write_i  (tx_write_i),
    .tx_credit_o (tx_credit_o),
    .tx_empty_o  (tx_empty),
    .tx_idle_o   (tx_idle),
    .txd_o       (txd_o)
  );

  uart_rx #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CNT_W      (CNT_W)
  ) rx_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .tick_i       (tick),
    .parity_en_i  (parity_en_i),
    .rxd_i        (rxd_i),
    .rx_read_i    (rx_read_i),
    .rx_data_o    (rx_data_o),
    .rx_count_o   (rx_count_o),
    .frame_done_o (frame_done),
    .parity_err_o (parity_err),
    .frame_err_o  (frame_err),
    .overrun_o    (overrun),
    .underrun_o   (underrun)
  );

  uart_line_status #(
    .CNT_W (CNT_W)
  ) line_status_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .ier_i         (ier_i),
    .trigger_i     (trigger_i),
    .status_read_i (status_read_i),
    .rx_count_i    (rx_count_o),
    .frame_done_i  (frame_done),
    .parity_err_i  (parity_err),
    .frame_err_i   (frame_err),
    .overrun_i     (overrun),
    .underrun_i    (underrun),
    .tx_empty_i    (tx_empty),
    .tx_idle_i     (tx_idle),
    .lsr_o         (lsr_o),
    .iir_o         (iir_o),
    .irq_o         (irq_o)
  );

endmodule

/* rtl/uart_line_status.sv */
`timescale 1ns/10ps

module uart_line_status #(
  parameter int CNT_W = 4
) (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic [2:0]                   ier_i,
  input  logic [CNT_W-1:0]             trigger_i,
  input  logic                         status_read_i,
  input  logic [CNT_W-1:0]             rx_count_i,
  input  logic                         frame_done_i,
  input  logic                         parity_err_i,
  input  logic                         frame_err_i,
  input  logic                         overrun_i,
  input  logic                         underrun_i,
  input  logic                         tx_empty_i,
  input  logic                         tx_idle_i,
  output logic [uart_pkg::LSR_W-1:0]   lsr_o,
  output logic [uart_pkg::IIR_W-1:0]   iir_o,
  output logic                         irq_o
);

  // tx side empty and idle out of reset
  localparam logic [uart_pkg::LSR_W-1:0] LSR_RST =
    uart_pkg::LSR_W'((1 << uart_pkg::LSR_TFE) | (1 << uart_pkg::LSR_TEMT));

  logic [uart_pkg::LSR_W-1:0] lsr;
  logic                       keep;      // sticky bits hold unless read
  logic                       rls_int;
  logic                       rda_int;
  logic                       thre_int;

  assign keep  = !status_read_i;
  assign lsr_o = lsr;

  // ------------------------------------------------------------------
  // status bits with set winning over the clearing read
  // ------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst_i)
      lsr <= LSR_RST;
    else
    begin
      lsr[uart_pkg::LSR_DR]   <= (rx_count_i != '0);
      lsr[uart_pkg::LSR_OE]   <= overrun_i | (lsr[uart_pkg::LSR_OE] & keep);
      lsr[uart_pkg::LSR_PE]   <= (frame_done_i & parity_err_i)
                                 | (lsr[uart_pkg::LSR_PE] & keep);
      lsr[uart_pkg::LSR_FE]   <= (frame_done_i & frame_err_i)
                                 | (lsr[uart_pkg::LSR_FE] & keep);
      lsr[uart_pkg::LSR_UE]   <= underrun_i | (lsr[uart_pkg::LSR_UE] & keep);
      lsr[uart_pkg::LSR_TFE]  <= tx_empty_i;
      lsr[uart_pkg::LSR_TEMT] <= tx_idle_i;
    end
  end

  // ------------------------------------------------------------------
  // interrupt conditions and priority
  // ------------------------------------------------------------------
  assign rls_int  = ier_i[uart_pkg::IER_RLS]
                    & (lsr[uart_pkg::LSR_OE] | lsr[uart_pkg::LSR_PE]
                       | lsr[uart_pkg::LSR_FE] | lsr[uart_pkg::LSR_UE]);
  assign rda_int  = ier_i[uart_pkg::IER_RDA] & (trigger_i != '0)  // trigger 0 disables
                    & (rx_count_i >= trigger_i);
  assign thre_int = ier_i[uart_pkg::IER_THRE] & lsr[uart_pkg::LSR_TFE];

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      iir_o <= uart_pkg::IIR_NONE;
      irq_o <= 1'b0;
    end
    else
    begin
      irq_o <= rls_int | rda_int | thre_int;
      if (rls_int)
        iir_o <= uart_pkg::IIR_RLS;
      else if (rda_int)
        iir_o <= uart_pkg::IIR_RDA;
      else if (thre_int)
        iir_o <= uart_pkg::IIR_THRE;
      else
        iir_o <= uart_pkg::IIR_NONE;
    end
  end

  a_irq_has_id : assert property (
    @(posedge clk) disable iff (rst_i) irq_o |-> iir_o != uart_pkg::IIR_NONE);

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
  parameter int FIFO_DEPTH = 8,
  parameter int CNT_W      = 4
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        tick_i,
  input  logic                        parity_en_i,
  input  logic                        rxd_i,
  input  logic                        rx_read_i,
  output logic [uart_pkg::DATA_W-1:0] rx_data_o,
  output logic [CNT_W-1:0]            rx_count_o,
  output logic                        frame_done_o,
  output logic                        parity_err_o,
  output logic                        frame_err_o,
  output logic                        overrun_o,
  output logic                        underrun_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int TCK_W = $clog2(uart_pkg::OVERSAMPLE);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;  // waiting for mid start bit
  localparam logic [1:0] S_BITS  = 2'd2;  // data, parity, stop

  logic                        sync1;
  logic                        rxd_s;     // synchronized line
  logic [1:0]                  state;
  logic [TCK_W-1:0]            tick_cnt;
  logic [3:0]                  bits_left;
  logic [uart_pkg::DATA_W:0]   shreg;     // parity and data, filled from msb
  logic [uart_pkg::DATA_W-1:0] rx_byte;
  logic                        sample;
  logic                        stop_sample;
  logic                        full;
  logic                        push;
  logic                        pop;
  logic [uart_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [CNT_W-1:0]            count;

  assign sample      = tick_i && (state == S_BITS)
                       && (tick_cnt == TCK_W'(uart_pkg::OVERSAMPLE - 1));
  assign stop_sample = sample && (bits_left == 4'd1);
  assign rx_byte     = parity_en_i ? shreg[uart_pkg::DATA_W-1:0]
                                   : shreg[uart_pkg::DATA_W:1];
  assign full        = (count == CNT_W'(FIFO_DEPTH));
  assign push        = stop_sample && !full;  // kept even with errors
  assign pop         = rx_read_i && (count != '0);

  assign rx_data_o  = mem[rd_ptr];
  assign rx_count_o = count;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      sync1 <= 1'b1;  // idle line level
      rxd_s <= 1'b1;
    end
    else
    begin
      sync1 <= rxd_i;
      rxd_s <= sync1;
    end
  end

  // ------------------------------------------------------------------
  // frame fsm
  // ------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      state     <= S_IDLE;
      tick_cnt  <= '0;
      bits_left <= '0;
    end
    else if (tick_i)
    begin
      case (state)
        S_IDLE:
          if (!rxd_s)
          begin
            state    <= S_START;
            tick_cnt <= '0;
          end
        S_START:
          if (tick_cnt == TCK_W'(uart_pkg::OVERSAMPLE / 2 - 1))
          begin
            state     <= rxd_s ? S_IDLE : S_BITS;  // high again, was a glitch
            tick_cnt  <= '0;
            bits_left <= parity_en_i ? 4'd10 : 4'd9;
          end
          else
            tick_cnt <= tick_cnt + 1'b1;
        S_BITS:
        begin
          tick_cnt <= tick_cnt + 1'b1;  // wraps at mid of next bit
          if (sample)
          begin
            bits_left <= bits_left - 1'b1;
            if (stop_sample)
              state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && !stop_sample)
      shreg <= {rxd_s, shreg[uart_pkg::DATA_W:1]};
  end

  // one-cycle events to line status
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      frame_done_o <= 1'b0;
      parity_err_o <= 1'b0;
      frame_err_o  <= 1'b0;
      overrun_o    <= 1'b0;
      underrun_o   <= 1'b0;
    end
    else
    begin
      frame_done_o <= stop_sample;
      parity_err_o <= stop_sample && parity_en_i && (^shreg);  // odd ones count
      frame_err_o  <= stop_sample && !rxd_s;                   // stop bit low
      overrun_o    <= stop_sample && full;                     // frame dropped
      underrun_o   <= rx_read_i && (count == '0);
    end
  end

  // ------------------------------------------------------------------
  // receive fifo
  // ------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= rx_byte;
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  a_count_bound : assert property (
    @(posedge clk) disable iff (rst_i) rx_count_o <= CNT_W'(FIFO_DEPTH));

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
  parameter int FIFO_DEPTH = 8,
  parameter int CNT_W      = 4
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        tick_i,
  input  logic                        parity_en_i,
  input  logic [uart_pkg::DATA_W-1:0] tx_data_i,
  input  logic                        tx_write_i,
  output logic [CNT_W-1:0]            tx_credit_o,
  output logic                        tx_empty_o,
  output logic                        tx_idle_o,
  output logic                        txd_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);  // depth is a power of two
  localparam int TCK_W = $clog2(uart_pkg::OVERSAMPLE);
  localparam int FRM_W = uart_pkg::DATA_W + 3;  // start, data, parity, stop

  logic [uart_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [CNT_W-1:0]            credit;     // free slots
  logic                        busy;
  logic [FRM_W-1:0]            frame;      // shifts out lsb first
  logic [3:0]                  bits_left;
  logic [TCK_W-1:0]            tick_cnt;
  logic                        empty;
  logic                        load;
  logic                        bit_end;

  assign empty   = (credit == CNT_W'(FIFO_DEPTH));
  assign load    = tick_i && !busy && !empty;  // frames start on a tick edge
  assign bit_end = tick_i && busy && (tick_cnt == TCK_W'(uart_pkg::OVERSAMPLE - 1));

  assign tx_credit_o = credit;
  assign tx_empty_o  = empty;
  assign tx_idle_o   = empty && !busy;
  assign txd_o       = frame[0];  // all ones while idle

  // ------------------------------------------------------------------
  // fifo and credit
  // ------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (tx_write_i)
      mem[wr_ptr] <= tx_data_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      credit <= CNT_W'(FIFO_DEPTH);
    end
    else
    begin
      if (tx_write_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (load)
        rd_ptr <= rd_ptr + 1'b1;
      case ({tx_write_i, load})
        2'b10:   credit <= credit - 1'b1;
        2'b01:   credit <= credit + 1'b1;  // slot freed by the shifter
        default: credit <= credit;         // both or neither, no change
      endcase
    end
  end

  // ------------------------------------------------------------------
  // serializer
  // ------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      busy      <= 1'b0;
      frame     <= '1;
      bits_left <= '0;
      tick_cnt  <= '0;
    end
    else if (load)
    begin
      busy      <= 1'b1;
      tick_cnt  <= '0;
      // even parity: parity bit makes the count of ones even
      frame     <= parity_en_i ? {1'b1, ^mem[rd_ptr], mem[rd_ptr], 1'b0}
                               : {2'b11, mem[rd_ptr], 1'b0};
      bits_left <= parity_en_i ? 4'd11 : 4'd10;
    end
    else if (tick_i && busy)
    begin
      tick_cnt <= tick_cnt + 1'b1;  // wraps at bit end
      if (bit_end)
      begin
        frame     <= {1'b1, frame[FRM_W-1:1]};
        bits_left <= bits_left - 1'b1;
        busy      <= (bits_left != 4'd1);  // stop bit done
      end
    end
  end

  // host must hold off writes while no slot is advertised
  a_write_needs_credit : assert property (
    @(posedge clk) disable iff (rst_i) tx_write_i |-> tx_credit_o != '0);

endmodule

/* rtl/uart_baud_gen.sv */
`timescale 1ns/10ps

module uart_baud_gen #(
  parameter int DIV_W = 12
) (
  input  logic             clk,
  input  logic             rst_i,
  input  logic [DIV_W-1:0] divisor_i,  // clocks per oversampling tick
  output logic             tick_o
);

  logic [DIV_W-1:0] cnt;  // counts down to the next tick

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      cnt    <= '0;
      tick_o <= 1'b0;
    end
    else if (divisor_i == '0)
    begin
      tick_o <= 1'b0;  // divisor 0 parks the core, count held
    end
    else if (cnt == '0)
    begin
      cnt    <= divisor_i - 1'b1;  // reload
      tick_o <= 1'b1;
    end
    else
    begin
      cnt    <= cnt - 1'b1;
      tick_o <= 1'b0;
    end
  end

endmodule

/* rtl/uart_pkg.sv */
package uart_pkg;

  // ------------------------------------------------------------------
  // character framing
  // ------------------------------------------------------------------
  localparam int DATA_W     = 8;   // bits per character
  localparam int OVERSAMPLE = 16;  // ticks per bit

  // ------------------------------------------------------------------
  // line status vector
  // ------------------------------------------------------------------
  localparam int LSR_W    = 7;
  localparam int LSR_DR   = 0;  // rx data ready
  localparam int LSR_OE   = 1;  // rx overrun, sticky
  localparam int LSR_PE   = 2;  // parity error, sticky
  localparam int LSR_FE   = 3;  // framing error, sticky
  localparam int LSR_UE   = 4;  // read of empty rx fifo, sticky
  localparam int LSR_TFE  = 5;  // tx fifo empty
  localparam int LSR_TEMT = 6;  // tx fifo empty and shifter idle

  // ------------------------------------------------------------------
  // interrupt identification, enables
  // ------------------------------------------------------------------
  localparam int IIR_W = 4;
  localparam logic [IIR_W-1:0] IIR_NONE = 4'b0001;  // bit 0 high: nothing pending
  localparam logic [IIR_W-1:0] IIR_RLS  = 4'b0110;  // line status, highest
  localparam logic [IIR_W-1:0] IIR_RDA  = 4'b0100;  // rx data at trigger
  localparam logic [IIR_W-1:0] IIR_THRE = 4'b0010;  // tx fifo empty, lowest

  localparam int IER_RLS  = 0;
  localparam int IER_RDA  = 1;
  localparam int IER_THRE = 2;

endpackage
